//--- Bender.yml
package:
  name: pinmux_core

sources:
  - design/pinmux_pkg.sv
  - design/reg_bus_if.sv
  - design/reg_bus_ctrl.sv
  - design/pinmux_timer.sv
  - design/gpio_regs.sv
  - design/irq_regs.sv
  - design/pinmux_core.sv
  - target: test
    files:
      - tests/pinmux_asserts.sv
      - tests/tb_pinmux.sv

//--- build.f
design/pinmux_pkg.sv
design/reg_bus_if.sv
design/reg_bus_ctrl.sv
design/pinmux_timer.sv
design/gpio_regs.sv
design/irq_regs.sv
design/pinmux_core.sv
tests/pinmux_asserts.sv
tests/tb_pinmux.sv

//--- design/gpio_regs.sv
// Pad inputs are asynchronous and pass two sync flops. Direction 1 means output
`timescale 1ns/10ps

module gpio_regs import pinmux_pkg::*; (
   input  logic              mclk_i,
   input  logic              rst_n_i,
   reg_bus_if.slave          bus_s,
   input  logic [GPIO_N-1:0] gpio_in_i,
   output logic [GPIO_N-1:0] gpio_out_o,
   output logic [GPIO_N-1:0] gpio_oen_o,
   output logic              gpio_intr_o
);

   logic [GPIO_N-1:0] dir_q;
   logic [GPIO_N-1:0] out_q;
   logic [GPIO_N-1:0] int_en_q;
   logic [GPIO_N-1:0] int_stat_q;
   logic [GPIO_N-1:0] sync1_q;
   logic [GPIO_N-1:0] in_q;
   logic [GPIO_N-1:0] in_d_q;
   logic [GPIO_N-1:0] rise;
   logic [GPIO_N-1:0] stat_clr;
   logic              ack_q;
   logic              wr_stb;

   assign wr_stb    = bus_s.sel && !ack_q && bus_s.wr;
   assign bus_s.ack = ack_q;

   // Pad side
   assign gpio_out_o  = out_q;
   assign gpio_oen_o  = ~dir_q;
   assign gpio_intr_o = |(int_stat_q & int_en_q);

   // Rising edge on enabled pins only
   assign rise     = in_q & ~in_d_q & int_en_q;
   // Clear mask for write-one-to-clear status
   assign stat_clr = (wr_stb && (bus_s.ofs == GPIO_INT_STAT))
                   ? be_merge('0, bus_s.wdata, bus_s.be) : '0;

   // ----------------------------------------
   // Input sync and edge detect
   // ----------------------------------------
   always_ff @(posedge mclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sync1_q    <= '0;
         in_q       <= '0;
         in_d_q     <= '0;
         int_stat_q <= '0;
      end else begin
         sync1_q    <= gpio_in_i;
         in_q       <= sync1_q;
         in_d_q     <= in_q;
         // New edge wins over a clear in the same cycle
         int_stat_q <= (int_stat_q & ~stat_clr) | rise;
      end
   end

   // ----------------------------------------
   // Config registers
   // ----------------------------------------
   always_ff @(posedge mclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q    <= 1'b0;
         dir_q    <= '0;
         out_q    <= '0;
         int_en_q <= '0;
      end else begin
         ack_q <= bus_s.sel && !ack_q;
         if (wr_stb) begin
            case (bus_s.ofs)
               GPIO_DIR:    dir_q    <= be_merge(dir_q, bus_s.wdata, bus_s.be);
               GPIO_OUT:    out_q    <= be_merge(out_q, bus_s.wdata, bus_s.be);
               GPIO_INT_EN: int_en_q <= be_merge(int_en_q, bus_s.wdata, bus_s.be);
               default: ;
            endcase
         end
      end
   end

   // GPIO_IN has no write path
   always_comb begin
      case (bus_s.ofs)
         GPIO_DIR:      bus_s.rdata = dir_q;
         GPIO_OUT:      bus_s.rdata = out_q;
         GPIO_IN:       bus_s.rdata = in_q;
         GPIO_INT_EN:   bus_s.rdata = int_en_q;
         GPIO_INT_STAT: bus_s.rdata = int_stat_q;
         default:       bus_s.rdata = '0;
      endcase
   end

endmodule

//--- design/irq_regs.sv
// GPIO status bit is a level from gpio_regs and clears at the source. Timer bits are sticky
`timescale 1ns/10ps

module irq_regs import pinmux_pkg::*; (
   input  logic             mclk_i,
   input  logic             rst_n_i,
   reg_bus_if.slave         bus_s,
   input  logic             gpio_intr_i,
   input  logic [TMR_N-1:0] timer_intr_i,
   output logic             irq_o,
   output logic             soft_irq_o
);

   logic [REG_DW-1:0] mask_q;
   logic [TMR_N-1:0]  tmr_stat_q;
   logic              soft_q;
   logic [REG_DW-1:0] stat_w;
   logic [REG_DW-1:0] stat_clr;
   logic              ack_q;
   logic              wr_stb;

   assign wr_stb    = bus_s.sel && !ack_q && bus_s.wr;
   assign bus_s.ack = ack_q;

   // Status word assembly
   always_comb begin
      stat_w                             = '0;
      stat_w[IRQ_GPIO_BIT]               = gpio_intr_i;
      stat_w[IRQ_TMR_BIT +: TMR_N]       = tmr_stat_q;
   end

   assign stat_clr = (wr_stb && (bus_s.ofs == IRQ_STAT))
                   ? be_merge('0, bus_s.wdata, bus_s.be) : '0;

   // Combined outputs
   assign irq_o      = |(stat_w & mask_q);
   assign soft_irq_o = soft_q;

   // ----------------------------------------
   // Mask, status and soft interrupt
   // ----------------------------------------
   always_ff @(posedge mclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q      <= 1'b0;
         mask_q     <= '0;
         tmr_stat_q <= '0;
         soft_q     <= 1'b0;
      end else begin
         ack_q      <= bus_s.sel && !ack_q;
         tmr_stat_q <= (tmr_stat_q & ~stat_clr[IRQ_TMR_BIT +: TMR_N]) | timer_intr_i;
         if (wr_stb && (bus_s.ofs == IRQ_MASK)) begin
            mask_q <= be_merge(mask_q, bus_s.wdata, bus_s.be);
         end
         // Only bit 0 of SOFT_IRQ is implemented
         if (wr_stb && (bus_s.ofs == SOFT_IRQ) && bus_s.be[0]) begin
            soft_q <= bus_s.wdata[0];
         end
      end
   end

   always_comb begin
      case (bus_s.ofs)
         IRQ_MASK: bus_s.rdata = mask_q;
         IRQ_STAT: bus_s.rdata = stat_w;
         SOFT_IRQ: bus_s.rdata = REG_DW'(soft_q);
         default:  bus_s.rdata = '0;
      endcase
   end

endmodule

//--- design/pinmux_core.sv
// Peripheral block top. Single mclk domain and one async active low reset
`timescale 1ns/10ps

module pinmux_core import pinmux_pkg::*; (
   input  logic              mclk_i,
   input  logic              rst_n_i,
   // Register bus
   input  logic              reg_cs_i,
   input  logic              reg_wr_i,
   input  logic [REG_AW-1:0] reg_addr_i,
   input  logic [REG_DW-1:0] reg_wdata_i,
   input  logic [REG_BW-1:0] reg_be_i,
   output logic [REG_DW-1:0] reg_rdata_o,
   output logic              reg_ack_o,
   // Pads
   input  logic [GPIO_N-1:0] gpio_in_i,
   output logic [GPIO_N-1:0] gpio_out_o,
   output logic [GPIO_N-1:0] gpio_oen_o,
   // Interrupts and tick
   output logic              irq_o,
   output logic              soft_irq_o,
   output logic              pulse_1us_o
);

   // Sideband interrupt wires
   logic             gpio_intr;
   logic [TMR_N-1:0] timer_intr;

   // One bus per slave
   reg_bus_if glbl_bus ();
   reg_bus_if gpio_bus ();
   reg_bus_if tmr_bus ();

   // ----------------------------------------
   // Bus controller
   // ----------------------------------------
   reg_bus_ctrl u_ctrl (
      .mclk_i      (mclk_i),
      .rst_n_i     (rst_n_i),
      .reg_cs_i    (reg_cs_i),
      .reg_wr_i    (reg_wr_i),
      .reg_addr_i  (reg_addr_i),
      .reg_wdata_i (reg_wdata_i),
      .reg_be_i    (reg_be_i),
      .reg_rdata_o (reg_rdata_o),
      .reg_ack_o   (reg_ack_o),
      .glbl_m      (glbl_bus.ctrl),
      .gpio_m      (gpio_bus.ctrl),
      .tmr_m       (tmr_bus.ctrl)
   );

   // ----------------------------------------
   // Slaves
   // ----------------------------------------
   irq_regs u_irq (
      .mclk_i       (mclk_i),
      .rst_n_i      (rst_n_i),
      .bus_s        (glbl_bus.slave),
      .gpio_intr_i  (gpio_intr),
      .timer_intr_i (timer_intr),
      .irq_o        (irq_o),
      .soft_irq_o   (soft_irq_o)
   );

   gpio_regs u_gpio (
      .mclk_i      (mclk_i),
      .rst_n_i     (rst_n_i),
      .bus_s       (gpio_bus.slave),
      .gpio_in_i   (gpio_in_i),
      .gpio_out_o  (gpio_out_o),
      .gpio_oen_o  (gpio_oen_o),
      .gpio_intr_o (gpio_intr)
   );

   pinmux_timer u_timer (
      .mclk_i       (mclk_i),
      .rst_n_i      (rst_n_i),
      .bus_s        (tmr_bus.slave),
      .pulse_1us_o  (pulse_1us_o),
      .timer_intr_o (timer_intr)
   );

endmodule

//--- design/pinmux_pkg.sv
// Shared constants for the register bus. GPIO_N must equal REG_DW and CLK_PER_US assumes 50 MHz mclk
package pinmux_pkg;

   // ----------------------------------------
   // Bus geometry
   // ----------------------------------------
   localparam int REG_AW = 10;
   localparam int REG_DW = 32;
   localparam int REG_BW = 4;
   localparam int OFS_W  = 4;    // Word offset from addr[5:2]
   localparam int SEL_W  = 3;    // Region field from addr[9:7]

   // Peripheral sizing
   localparam int GPIO_N     = 32;
   localparam int TMR_N      = 2;
   localparam int TMR_W      = 16;
   localparam int TMR_EN_BIT = 16;
   localparam int CLK_PER_US = 50;
   localparam int US_CNT_W   = $clog2(CLK_PER_US);

   // Region codes
   localparam logic [SEL_W-1:0] SEL_GLBL  = 3'd0;
   localparam logic [SEL_W-1:0] SEL_GPIO  = 3'd1;
   localparam logic [SEL_W-1:0] SEL_TIMER = 3'd3;

   // ----------------------------------------
   // Register offsets
   // ----------------------------------------
   localparam logic [OFS_W-1:0] IRQ_MASK      = 4'd0;
   localparam logic [OFS_W-1:0] IRQ_STAT      = 4'd1;
   localparam logic [OFS_W-1:0] SOFT_IRQ      = 4'd2;

   localparam logic [OFS_W-1:0] GPIO_DIR      = 4'd0;
   localparam logic [OFS_W-1:0] GPIO_OUT      = 4'd1;
   localparam logic [OFS_W-1:0] GPIO_IN       = 4'd2;
   localparam logic [OFS_W-1:0] GPIO_INT_EN   = 4'd3;
   localparam logic [OFS_W-1:0] GPIO_INT_STAT = 4'd4;

   localparam logic [OFS_W-1:0] TMR_CFG0      = 4'd0;
   localparam logic [OFS_W-1:0] TMR_CFG1      = 4'd1;
   localparam logic [OFS_W-1:0] TMR_CNT0      = 4'd2;
   localparam logic [OFS_W-1:0] TMR_CNT1      = 4'd3;

   // Interrupt status bit positions
   localparam int IRQ_GPIO_BIT = 0;
   localparam int IRQ_TMR_BIT  = 1;

   typedef enum logic [1:0] {IDLE, ACCESS, RESPOND, RELEASE} bus_state_e;

   // Byte lane merge of new data into an old word
   function automatic logic [REG_DW-1:0] be_merge(input logic [REG_DW-1:0] old_val,
                                                  input logic [REG_DW-1:0] new_val,
                                                  input logic [REG_BW-1:0] be);
      logic [REG_DW-1:0] mask;
      for (int b = 0; b < REG_BW; b++) begin
         mask[8*b +: 8] = {8{be[b]}};
      end
      return (old_val & ~mask) | (new_val & mask);
   endfunction

endpackage

//--- design/pinmux_timer.sv
// Two reload timers on a 1 us tick. Reload N fires every N+1 us and a config write restarts the count
`timescale 1ns/10ps

module pinmux_timer import pinmux_pkg::*; (
   input  logic             mclk_i,
   input  logic             rst_n_i,
   reg_bus_if.slave         bus_s,
   output logic             pulse_1us_o,
   output logic [TMR_N-1:0] timer_intr_o
);

   logic [US_CNT_W-1:0]              pre_cnt_q;
   logic [TMR_N-1:0]                 en_q;
   logic [TMR_N-1:0][TMR_W-1:0]      reload_q;
   logic [TMR_N-1:0][TMR_W-1:0]      cnt_q;
   logic [TMR_N-1:0][REG_DW-1:0]     cfg_word;
   logic [TMR_N-1:0][REG_DW-1:0]     cfg_new;
   logic                             ack_q;
   logic                             wr_stb;

   // Write happens on the first cycle of sel
   assign wr_stb    = bus_s.sel && !ack_q && bus_s.wr;
   assign bus_s.ack = ack_q;

   // ----------------------------------------
   // Microsecond prescaler
   // ----------------------------------------
   always_ff @(posedge mclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pre_cnt_q   <= '0;
         pulse_1us_o <= 1'b0;
      end else if (pre_cnt_q == US_CNT_W'(CLK_PER_US - 1)) begin
         pre_cnt_q   <= '0;
         pulse_1us_o <= 1'b1;
      end else begin
         pre_cnt_q   <= pre_cnt_q + 1'b1;
         pulse_1us_o <= 1'b0;
      end
   end

   // Config word layout is enable above reload
   always_comb begin
      for (int k = 0; k < TMR_N; k++) begin
         cfg_word[k] = REG_DW'({en_q[k], reload_q[k]});
         cfg_new[k]  = be_merge(cfg_word[k], bus_s.wdata, bus_s.be);
      end
   end

   // ----------------------------------------
   // Reload down-counters
   // ----------------------------------------
   always_ff @(posedge mclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q        <= 1'b0;
         en_q         <= '0;
         reload_q     <= '0;
         cnt_q        <= '0;
         timer_intr_o <= '0;
      end else begin
         ack_q <= bus_s.sel && !ack_q;
         for (int k = 0; k < TMR_N; k++) begin
            timer_intr_o[k] <= 1'b0;
            if (wr_stb && (bus_s.ofs == OFS_W'(TMR_CFG0 + k))) begin
               reload_q[k] <= cfg_new[k][TMR_W-1:0];
               en_q[k]     <= cfg_new[k][TMR_EN_BIT];
               cnt_q[k]    <= cfg_new[k][TMR_W-1:0];
            end else if (en_q[k] && pulse_1us_o) begin
               if (cnt_q[k] == '0) begin
                  // Terminal count
                  timer_intr_o[k] <= 1'b1;
                  cnt_q[k]        <= reload_q[k];
               end else begin
                  cnt_q[k] <= cnt_q[k] - 1'b1;
               end
            end
         end
      end
   end

   // Read mux, valid while sel is high
   always_comb begin
      case (bus_s.ofs)
         TMR_CFG0: bus_s.rdata = cfg_word[0];
         TMR_CFG1: bus_s.rdata = cfg_word[1];
         TMR_CNT0: bus_s.rdata = REG_DW'(cnt_q[0]);
         TMR_CNT1: bus_s.rdata = REG_DW'(cnt_q[1]);
         default:  bus_s.rdata = '0;
      endcase
   end

endmodule

//--- design/reg_bus_ctrl.sv
// Master must hold reg_cs_i until reg_ack_o and start a new access only after ack drops
`timescale 1ns/10ps

module reg_bus_ctrl import pinmux_pkg::*; (
   input  logic              mclk_i,
   input  logic              rst_n_i,
   input  logic              reg_cs_i,
   input  logic              reg_wr_i,
   input  logic [REG_AW-1:0] reg_addr_i,
   input  logic [REG_DW-1:0] reg_wdata_i,
   input  logic [REG_BW-1:0] reg_be_i,
   output logic [REG_DW-1:0] reg_rdata_o,
   output logic              reg_ack_o,
   reg_bus_if.ctrl           glbl_m,
   reg_bus_if.ctrl           gpio_m,
   reg_bus_if.ctrl           tmr_m
);

   bus_state_e        state_q;
   logic              wr_q;
   logic [REG_AW-1:0] addr_q;
   logic [REG_DW-1:0] wdata_q;
   logic [REG_BW-1:0] be_q;
   logic [REG_DW-1:0] rdata_q;
   logic [SEL_W-1:0]  region;
   logic              mapped;
   logic              take_req;
   logic              any_ack;
   logic [REG_DW-1:0] ack_rdata;
   logic              glbl_sel_q;
   logic              gpio_sel_q;
   logic              tmr_sel_q;
   logic              none_sel_q;
   logic              none_ack_q;

   // ----------------------------------------
   // Decode and response steering
   // ----------------------------------------
   assign region   = addr_q[REG_AW-1 -: SEL_W];
   assign mapped   = (region == SEL_GLBL) || (region == SEL_GPIO) || (region == SEL_TIMER);
   // Back to back accesses may start straight from RELEASE
   assign take_req = reg_cs_i && ((state_q == IDLE) || (state_q == RELEASE));
   assign any_ack  = glbl_m.ack | gpio_m.ack | tmr_m.ack | none_ack_q;

   // Only the acking slave contributes, unmapped returns zero
   assign ack_rdata = ({REG_DW{glbl_m.ack}} & glbl_m.rdata)
                    | ({REG_DW{gpio_m.ack}} & gpio_m.rdata)
                    | ({REG_DW{tmr_m.ack}}  & tmr_m.rdata);

   assign reg_ack_o   = (state_q == RESPOND);
   assign reg_rdata_o = rdata_q;

   // Request capture
   always_ff @(posedge mclk_i) begin
      if (take_req) begin
         wr_q    <= reg_wr_i;
         addr_q  <= reg_addr_i;
         wdata_q <= reg_wdata_i;
         be_q    <= reg_be_i;
      end
      if ((state_q == ACCESS) && any_ack) begin
         rdata_q <= ack_rdata;
      end
   end

   // ----------------------------------------
   // Handshake FSM
   // ----------------------------------------
   always_ff @(posedge mclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q    <= IDLE;
         glbl_sel_q <= 1'b0;
         gpio_sel_q <= 1'b0;
         tmr_sel_q  <= 1'b0;
         none_sel_q <= 1'b0;
         none_ack_q <= 1'b0;
      end else begin
         // Stand-in slave so unmapped regions keep the same latency
         none_ack_q <= none_sel_q && !none_ack_q;
         case (state_q)
            IDLE, RELEASE: begin
               state_q <= take_req ? ACCESS : IDLE;
            end
            ACCESS: begin
               if (any_ack) begin
                  glbl_sel_q <= 1'b0;
                  gpio_sel_q <= 1'b0;
                  tmr_sel_q  <= 1'b0;
                  none_sel_q <= 1'b0;
                  state_q    <= RESPOND;
               end else begin
                  glbl_sel_q <= (region == SEL_GLBL);
                  gpio_sel_q <= (region == SEL_GPIO);
                  tmr_sel_q  <= (region == SEL_TIMER);
                  none_sel_q <= !mapped;
               end
            end
            RESPOND: begin
               // Wait as long as the master holds select
               if (!reg_cs_i) begin
                  state_q <= RELEASE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Request fields fan out to every slave
   assign glbl_m.sel   = glbl_sel_q;
   assign glbl_m.wr    = wr_q;
   assign glbl_m.ofs   = addr_q[OFS_W+1:2];
   assign glbl_m.wdata = wdata_q;
   assign glbl_m.be    = be_q;

   assign gpio_m.sel   = gpio_sel_q;
   assign gpio_m.wr    = wr_q;
   assign gpio_m.ofs   = addr_q[OFS_W+1:2];
   assign gpio_m.wdata = wdata_q;
   assign gpio_m.be    = be_q;

   assign tmr_m.sel    = tmr_sel_q;
   assign tmr_m.wr     = wr_q;
   assign tmr_m.ofs    = addr_q[OFS_W+1:2];
   assign tmr_m.wdata  = wdata_q;
   assign tmr_m.be     = be_q;

endmodule

//--- design/reg_bus_if.sv
// One controller and one slave per instance. The slave must pulse ack one cycle after sel
`timescale 1ns/10ps

interface reg_bus_if import pinmux_pkg::*; ();

   // Request fields from the controller
   logic              sel;
   logic              wr;
   logic [OFS_W-1:0]  ofs;
   logic [REG_DW-1:0] wdata;
   logic [REG_BW-1:0] be;

   // Response from the slave
   logic [REG_DW-1:0] rdata;
   logic              ack;

   modport ctrl (
      output sel, wr, ofs, wdata, be,
      input  rdata, ack
   );

   modport slave (
      input  sel, wr, ofs, wdata, be,
      output rdata, ack
   );

endinterface

//--- tests/pinmux_asserts.sv
// Outer bus handshake rules. Checks are idle while rst_n_i is low
`timescale 1ns/10ps

module pinmux_asserts (
   input logic mclk_i,
   input logic rst_n_i,
   input logic reg_cs_i,
   input logic reg_ack_i
);

   // Failed assertion count
   int fail_cnt = 0;

   // ----------------------------------------
   // Four-phase handshake
   // ----------------------------------------
   // Ack only answers a held select
   ack_needs_cs: assert property (@(posedge mclk_i) disable iff (!rst_n_i)
      $rose(reg_ack_i) |-> $past(reg_cs_i))
      else begin
         $error("reg_ack_o rose while reg_cs_i was low");
         fail_cnt++;
      end

   // Controller waits in RESPOND
   ack_holds: assert property (@(posedge mclk_i) disable iff (!rst_n_i)
      (reg_ack_i && reg_cs_i) |=> reg_ack_i)
      else begin
         $error("reg_ack_o dropped while reg_cs_i was still high");
         fail_cnt++;
      end

   // Release takes exactly one cycle
   ack_release: assert property (@(posedge mclk_i) disable iff (!rst_n_i)
      $fell(reg_cs_i) |-> reg_ack_i ##1 !reg_ack_i)
      else begin
         $error("reg_ack_o did not fall one cycle after reg_cs_i");
         fail_cnt++;
      end

endmodule

bind pinmux_core pinmux_asserts u_asserts (
   .mclk_i    (mclk_i),
   .rst_n_i   (rst_n_i),
   .reg_cs_i  (reg_cs_i),
   .reg_ack_i (reg_ack_o)
);

//--- tests/pinmux_input.txt
# Columns: op addr data be, all hex. W write data with be, R read and expect data
# P drive pads with data, I wait for irq_o to equal data bit 0. Unused columns are 0
R 000 00000000 0
R 004 00000000 0
R 008 00000000 0
R 080 00000000 0
R 084 00000000 0
R 088 00000000 0
R 08c 00000000 0
R 090 00000000 0
R 180 00000000 0
R 184 00000000 0
R 188 00000000 0
R 18c 00000000 0
I 000 00000000 0
W 080 a5a5ffff c
R 080 a5a50000 0
W 084 12345678 3
R 084 00005678 0
P 000 0000f00f 0
R 088 0000f00f 0
W 08c 00000100 f
W 000 00000001 f
P 000 0000f10f 0
I 000 00000001 0
R 090 00000100 0
R 004 00000001 0
W 090 00000100 f
I 000 00000000 0
R 090 00000000 0
W 000 00000002 f
W 180 00010002 f
I 000 00000001 0
R 004 00000002 0
W 180 00000002 f
R 180 00000002 0
R 188 00000002 0
W 004 00000002 f
I 000 00000000 0
R 100 00000000 0
W 200 ffffffff f
R 200 00000000 0

//--- tests/tb_pinmux.sv
// Run from the project root so tests/pinmux_input.txt is found. Timer waits assume a 50 MHz mclk
`timescale 1ns/10ps

module tb_pinmux import pinmux_pkg::*; ();

   localparam int          CLK_HALF    = 10;
   localparam int          DRV_DLY     = 2;
   localparam int          ACK_LAT     = 3;
   localparam int          ACK_TIMEOUT = 16;
   localparam int          CS_HOLD     = 2;
   localparam int          IRQ_TIMEOUT = 2000;
   localparam logic [31:0] SEED        = 32'h8e90_9c9a;

   logic              mclk;
   logic              rst_n;
   logic              reg_cs;
   logic              reg_wr;
   logic [REG_AW-1:0] reg_addr;
   logic [REG_DW-1:0] reg_wdata;
   logic [REG_BW-1:0] reg_be;
   logic [REG_DW-1:0] reg_rdata;
   logic              reg_ack;
   logic [GPIO_N-1:0] gpio_in;
   logic [GPIO_N-1:0] gpio_out;
   logic [GPIO_N-1:0] gpio_oen;
   logic              irq;
   logic              soft_irq;
   logic              pulse_1us;
   int                errors;
   int                tests;

   pinmux_core uut (
      .mclk_i      (mclk),
      .rst_n_i     (rst_n),
      .reg_cs_i    (reg_cs),
      .reg_wr_i    (reg_wr),
      .reg_addr_i  (reg_addr),
      .reg_wdata_i (reg_wdata),
      .reg_be_i    (reg_be),
      .reg_rdata_o (reg_rdata),
      .reg_ack_o   (reg_ack),
      .gpio_in_i   (gpio_in),
      .gpio_out_o  (gpio_out),
      .gpio_oen_o  (gpio_oen),
      .irq_o       (irq),
      .soft_irq_o  (soft_irq),
      .pulse_1us_o (pulse_1us)
   );

   // 20 ns clock
   initial begin
      mclk = 1'b0;
      forever begin
         #CLK_HALF mclk = ~mclk;
      end
   end

   // ----------------------------------------
   // Helpers
   // ----------------------------------------
   // Region in addr[9:7], word offset in addr[5:2]
   function automatic logic [REG_AW-1:0] addr_of(input logic [2:0] region,
                                                 input logic [3:0] ofs);
      return {region, 1'b0, ofs, 2'b00};
   endfunction

   // Inputs change just after the rising edge
   task automatic next_cycle();
      @(posedge mclk);
      #DRV_DLY;
   endtask

   task automatic check_value(input string what, input logic [REG_DW-1:0] got,
                              input logic [REG_DW-1:0] exp);
      assert (got === exp) else begin
         $display("error @%0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int errs_at);
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == errs_at) ? "ok" : "mismatch");
   endtask

   // Four-phase access: cs up, ack up, cs down, ack down
   task automatic bus_access(input logic wr, input logic [REG_AW-1:0] addr,
                             input logic [REG_DW-1:0] wdata, input logic [REG_BW-1:0] be,
                             output logic [REG_DW-1:0] rdata);
      int n;
      n         = 0;
      rdata     = '0;
      reg_cs    = 1'b1;
      reg_wr    = wr;
      reg_addr  = addr;
      reg_wdata = wdata;
      reg_be    = be;
      while (!reg_ack && (n < ACK_TIMEOUT)) begin
         next_cycle();
         n++;
      end
      if (!reg_ack) begin
         $display("timeout at %0t: no acknowledge for address 0x%03h", $time, addr);
         errors++;
      end else begin
         // First edge only samples cs
         assert (n - 1 == ACK_LAT) else begin
            $display("error @%0t: ack after %0d cycles, expected %0d", $time, n - 1, ACK_LAT);
            errors++;
         end
         rdata = reg_rdata;
         // Master keeps select a while, ack must stay
         for (int h = 0; h < CS_HOLD; h++) begin
            next_cycle();
            assert (reg_ack === 1'b1) else begin
               $display("error @%0t: acknowledge fell while select was high", $time);
               errors++;
            end
         end
      end
      reg_cs = 1'b0;
      n      = 0;
      while (reg_ack && (n < ACK_TIMEOUT)) begin
         next_cycle();
         n++;
      end
      if (reg_ack) begin
         $display("timeout at %0t: acknowledge stayed high after select fell", $time);
         errors++;
      end
   endtask

   task automatic wait_irq(input logic level);
      int n;
      n = 0;
      while ((irq !== level) && (n < IRQ_TIMEOUT)) begin
         next_cycle();
         n++;
      end
      assert (irq === level) else begin
         $display("timeout at %0t: irq_o never reached level %0b", $time, level);
         errors++;
      end
   endtask

   // Width and period of the microsecond tick
   task automatic check_tick();
      int n;
      n = 0;
      while ((pulse_1us !== 1'b1) && (n < 2 * CLK_PER_US)) begin
         next_cycle();
         n++;
      end
      if (pulse_1us !== 1'b1) begin
         $display("timeout at %0t: pulse_1us_o never went high", $time);
         errors++;
      end else begin
         next_cycle();
         n = 1;
         check_value("pulse_1us_o width", REG_DW'(pulse_1us), 32'h0);
         while ((pulse_1us !== 1'b1) && (n < 2 * CLK_PER_US)) begin
            next_cycle();
            n++;
         end
         check_value("pulse_1us_o period", n, CLK_PER_US);
      end
   endtask

   // One line of the stimulus file
   task automatic run_op(input logic [7:0] op, input logic [REG_AW-1:0] addr,
                         input logic [REG_DW-1:0] data, input logic [REG_BW-1:0] be);
      logic [REG_DW-1:0] rd;
      int                errs_at;
      errs_at = errors;
      case (op)
         "W": bus_access(1'b1, addr, data, be, rd);
         "R": begin
            bus_access(1'b0, addr, '0, 4'hf, rd);
            check_value($sformatf("read 0x%03h", addr), rd, data);
            report_test($sformatf("read 0x%03h", addr), errs_at);
         end
         "P": begin
            gpio_in = data;
            // Two sync flops plus margin
            repeat (3) next_cycle();
         end
         "I": begin
            wait_irq(data[0]);
            report_test($sformatf("irq level %0b", data[0]), errs_at);
         end
         default: begin
            $display("unknown opcode %c in the stimulus file", op);
            errors++;
         end
      endcase
   endtask

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial begin
      int                fd;
      int                cnt;
      int                errs_at;
      logic [7:0]        op;
      logic [31:0]       f_addr;
      logic [31:0]       f_data;
      logic [31:0]       f_be;
      logic [REG_DW-1:0] rd;
      logic [REG_DW-1:0] rnd;
      logic [REG_DW-1:0] exp;
      string             line;
      errors    = 0;
      tests     = 0;
      rnd       = $urandom(SEED);
      rst_n     = 1'b0;
      reg_cs    = 1'b0;
      reg_wr    = 1'b0;
      reg_addr  = '0;
      reg_wdata = '0;
      reg_be    = '0;
      gpio_in   = '0;
      repeat (3) @(posedge mclk);
      #DRV_DLY;
      rst_n = 1'b1;
      next_cycle();

      // Pad and interrupt outputs straight out of reset
      errs_at = errors;
      assert ((gpio_oen === '1) && (gpio_out === '0) && (irq === 1'b0)
              && (soft_irq === 1'b0) && (reg_ack === 1'b0) && (pulse_1us === 1'b0)) else begin
         $display("error @%0t: reset outputs oen=%08h out=%08h irq=%b soft=%b ack=%b tick=%b",
                  $time, gpio_oen, gpio_out, irq, soft_irq, reg_ack, pulse_1us);
         errors++;
      end
      report_test("reset outputs", errs_at);

      fd = $fopen("tests/pinmux_input.txt", "r");
      if (fd == 0) begin
         $display("could not open the stimulus file tests/pinmux_input.txt");
         errors++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            cnt  = $fgets(line, fd);
            // Skip comments and blank lines
            if ((cnt > 0) && (line.getc(0) != "#")) begin
               cnt = $sscanf(line, "%c %h %h %h", op, f_addr, f_data, f_be);
               if (cnt == 4) begin
                  run_op(op, f_addr[REG_AW-1:0], f_data, f_be[REG_BW-1:0]);
               end
            end
         end
         $fclose(fd);
      end

      // Random output data, only lanes 0 and 2 written
      errs_at = errors;
      rnd     = $urandom();
      exp     = rnd & 32'h00ff_00ff;
      bus_access(1'b1, addr_of(SEL_GPIO, GPIO_DIR), 32'h0000_ffff, 4'hf, rd);
      bus_access(1'b1, addr_of(SEL_GPIO, GPIO_OUT), '0, 4'hf, rd);
      bus_access(1'b1, addr_of(SEL_GPIO, GPIO_OUT), rnd, 4'b0101, rd);
      bus_access(1'b0, addr_of(SEL_GPIO, GPIO_OUT), '0, 4'hf, rd);
      check_value("gpio out readback", rd, exp);
      check_value("gpio_out_o pins", gpio_out, exp);
      check_value("gpio_oen_o pins", gpio_oen, 32'hffff_0000);
      report_test("random gpio out", errs_at);

      // Software interrupt set then clear
      errs_at = errors;
      bus_access(1'b1, addr_of(SEL_GLBL, SOFT_IRQ), 32'h1, 4'h1, rd);
      check_value("soft_irq_o after set", REG_DW'(soft_irq), 32'h1);
      bus_access(1'b1, addr_of(SEL_GLBL, SOFT_IRQ), 32'h0, 4'h1, rd);
      check_value("soft_irq_o after clear", REG_DW'(soft_irq), 32'h0);
      report_test("soft irq", errs_at);

      // One clock wide tick every CLK_PER_US cycles
      errs_at = errors;
      check_tick();
      report_test("microsecond tick", errs_at);

      // Bound handshake checks
      if (uut.u_asserts.fail_cnt != 0) begin
         $display("handshake assertions failed %0d times", uut.u_asserts.fail_cnt);
         errors += uut.u_asserts.fail_cnt;
      end

      $display("tests %0d, errors %0d", tests, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule
